// File: hw/rv_ops_pkg.sv
package rv_ops_pkg;

    typedef enum logic [3:0] {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_AND = 4'h2,
        OP_OR  = 4'h3,
        OP_XOR = 4'h4,
        OP_SLT = 4'h5,
        OP_LUI = 4'h6,
        OP_BEQ = 4'h7,
        OP_BNE = 4'h8,
        OP_BLT = 4'h9,
        OP_LW  = 4'ha,
        OP_SW  = 4'hb
    } op_t;

    typedef enum logic [1:0] {
        UNIT_NONE = 2'd0,
        UNIT_ALU  = 2'd1,
        UNIT_MEM  = 2'd2
    } unit_t;

    function automatic unit_t op_unit(op_t op);
        case (op)
            OP_LUI:       return UNIT_NONE;
            OP_LW, OP_SW: return UNIT_MEM;
            default:      return UNIT_ALU;
        endcase
    endfunction

    function automatic logic is_branch(op_t op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT};
    endfunction

    // Register-register ops that also exist in immediate form
    function automatic logic has_imm_form(op_t op);
        return op inside {OP_ADD, OP_AND, OP_OR, OP_XOR, OP_SLT};
    endfunction

endpackage

// File: hw/rob_pkg.sv
package rob_pkg;

    localparam int ROB_DEPTH = 8;
    localparam int MEM_WORDS = 64;

    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;

    // Occupancy, one bit wider than a tag
    typedef logic [$clog2(ROB_DEPTH):0] rob_cnt_t;

    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_idx_t;

    // Word index into data memory
    typedef logic [$clog2(MEM_WORDS)-1:0] mem_idx_t;

    typedef enum logic [1:0] {
        ST_EMPTY       = 2'd0,
        ST_WAIT        = 2'd1,
        ST_STORE_READY = 2'd2,
        ST_DONE        = 2'd3
    } rob_state_t;

endpackage

// File: hw/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer
    import rv_ops_pkg::*;
    import rob_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     dispatch,
    input  op_t      op,
    input  logic     use_imm,
    input  reg_idx_t rd,
    input  word_t    src1,
    input  word_t    src2,
    input  word_t    imm,
    input  word_t    pc,
    input  logic     alu_ready,
    input  logic     mem_ready,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  word_t    cdb_value,
    input  logic     cdb_store,
    output logic     rob_full,
    output logic     alu_issue,
    output op_t      alu_op,
    output word_t    alu_a,
    output word_t    alu_b,
    output rob_tag_t alu_tag,
    output logic     mem_issue,
    output logic     mem_is_store,
    output word_t    mem_addr,
    output word_t    mem_data,
    output rob_tag_t mem_tag,
    output logic     ls_commit,
    output rob_tag_t ls_tag,
    output logic     commit,
    output rob_tag_t commit_tag,
    output reg_idx_t commit_rd,
    output word_t    commit_value,
    output logic     branch_taken,
    output word_t    branch_pc
);

    op_t        e_op    [ROB_DEPTH];
    reg_idx_t   e_rd    [ROB_DEPTH];
    word_t      e_a     [ROB_DEPTH];
    word_t      e_b     [ROB_DEPTH];
    word_t      e_val   [ROB_DEPTH];
    logic       e_taken [ROB_DEPTH];
    rob_state_t e_state [ROB_DEPTH];

    rob_tag_t head;
    rob_tag_t iss_ptr;
    rob_tag_t tail;
    rob_cnt_t count;
    rob_cnt_t iss_cnt;

    logic  accept;
    logic  iss_pend;
    logic  iss_fire;
    op_t   iss_op;
    unit_t iss_unit;
    op_t   head_op;
    logic  head_ready;
    logic  head_no_rd;

    assign rob_full = (count == rob_cnt_t'(ROB_DEPTH));
    assign accept   = dispatch && !rob_full;

    // In-order issue from the issue pointer
    assign iss_op   = e_op[iss_ptr];
    assign iss_unit = op_unit(iss_op);
    assign iss_pend = (iss_cnt != '0);

    assign alu_issue = iss_pend && (iss_unit == UNIT_ALU) && alu_ready;
    assign mem_issue = iss_pend && (iss_unit == UNIT_MEM) && mem_ready;
    // LUI has no unit and is stepped over
    assign iss_fire  = alu_issue || mem_issue || (iss_pend && (iss_unit == UNIT_NONE));

    assign alu_op  = iss_op;
    assign alu_a   = e_a[iss_ptr];
    assign alu_b   = e_b[iss_ptr];
    assign alu_tag = iss_ptr;

    // Memory ops keep their offset in the value field until write-back
    assign mem_is_store = (iss_op == OP_SW);
    assign mem_addr     = e_a[iss_ptr] + e_val[iss_ptr];
    assign mem_data     = e_b[iss_ptr];
    assign mem_tag      = iss_ptr;

    assign head_op    = e_op[head];
    assign head_ready = (e_state[head] == ST_DONE) || (e_state[head] == ST_STORE_READY);
    assign head_no_rd = is_branch(head_op) || (head_op == OP_SW);

    always_ff @(posedge clk) begin
        if (!rst) begin
            head         <= '0;
            iss_ptr      <= '0;
            tail         <= '0;
            count        <= '0;
            iss_cnt      <= '0;
            commit       <= 1'b0;
            branch_taken <= 1'b0;
            ls_commit    <= 1'b0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                e_state[i] <= ST_EMPTY;
            end
        end else begin
            if (cdb_valid) begin
                e_state[cdb_tag] <= cdb_store ? ST_STORE_READY : ST_DONE;
            end
            if (head_ready) begin
                e_state[head] <= ST_EMPTY;
                head          <= head + 1'b1;
            end
            if (accept) begin
                e_state[tail] <= (op == OP_LUI) ? ST_DONE : ST_WAIT;
                tail          <= tail + 1'b1;
            end
            if (iss_fire) begin
                iss_ptr <= iss_ptr + 1'b1;
            end
            count   <= count + rob_cnt_t'(accept) - rob_cnt_t'(head_ready);
            iss_cnt <= iss_cnt + rob_cnt_t'(accept) - rob_cnt_t'(iss_fire);

            commit       <= head_ready;
            branch_taken <= head_ready && is_branch(head_op) && e_taken[head];
            ls_commit    <= head_ready && (e_state[head] == ST_STORE_READY);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            e_op[tail]    <= op;
            e_rd[tail]    <= rd;
            e_a[tail]     <= src1;
            e_b[tail]     <= (use_imm && has_imm_form(op)) ? imm : src2;
            e_taken[tail] <= 1'b0;
            if (is_branch(op)) begin
                e_val[tail] <= pc + imm;
            end else begin
                e_val[tail] <= imm;
            end
        end
        if (cdb_valid) begin
            // Branch target was fixed at dispatch, only the outcome arrives
            if (is_branch(e_op[cdb_tag])) begin
                e_taken[cdb_tag] <= cdb_value[0];
            end else begin
                e_val[cdb_tag] <= cdb_value;
            end
        end
        if (head_ready) begin
            commit_tag   <= head;
            commit_rd    <= head_no_rd ? '0 : e_rd[head];
            commit_value <= head_no_rd ? '0 : e_val[head];
            branch_pc    <= e_val[head];
            ls_tag       <= head;
        end
    end

    a_cdb_hits_waiting: assert property (@(posedge clk) disable iff (!rst)
        cdb_valid |-> (e_state[cdb_tag] == ST_WAIT))
        else $error("result bus wrote entry %0d which was not waiting", cdb_tag);

    a_issue_waiting: assert property (@(posedge clk) disable iff (!rst)
        (alu_issue || mem_issue) |-> (e_state[iss_ptr] == ST_WAIT))
        else $error("issue from entry %0d which was not waiting", iss_ptr);

endmodule

// File: hw/alu_unit.sv
`timescale 1ns/1ps

module alu_unit
    import rv_ops_pkg::*;
    import rob_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     alu_issue,
    input  op_t      alu_op,
    input  word_t    alu_a,
    input  word_t    alu_b,
    input  rob_tag_t alu_tag,
    input  logic     alu_grant,
    output logic     alu_ready,
    output logic     alu_req,
    output word_t    alu_value,
    output rob_tag_t alu_tag_out
);

    word_t result;

    // Free again once the held result goes out on the bus
    assign alu_ready = !alu_req || alu_grant;

    always_comb begin
        case (alu_op)
            OP_ADD:  result = alu_a + alu_b;
            OP_SUB:  result = alu_a - alu_b;
            OP_AND:  result = alu_a & alu_b;
            OP_OR:   result = alu_a | alu_b;
            OP_XOR:  result = alu_a ^ alu_b;
            OP_SLT:  result = word_t'($signed(alu_a) < $signed(alu_b));
            // Branches return only the taken flag
            OP_BEQ:  result = word_t'(alu_a == alu_b);
            OP_BNE:  result = word_t'(alu_a != alu_b);
            OP_BLT:  result = word_t'($signed(alu_a) < $signed(alu_b));
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            alu_req <= 1'b0;
        end else if (alu_issue) begin
            alu_req <= 1'b1;
        end else if (alu_grant) begin
            alu_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_issue) begin
            alu_value   <= result;
            alu_tag_out <= alu_tag;
        end
    end

    a_no_overwrite: assert property (@(posedge clk) disable iff (!rst)
        alu_issue |-> (!alu_req || alu_grant))
        else $error("ALU issued while result for tag %0d still waits", alu_tag_out);

endmodule

// File: hw/mem_unit.sv
`timescale 1ns/1ps

module mem_unit
    import rob_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     mem_issue,
    input  logic     mem_is_store,
    input  word_t    mem_addr,
    input  word_t    mem_data,
    input  rob_tag_t mem_tag,
    input  logic     mem_grant,
    input  logic     ls_commit,
    input  rob_tag_t ls_tag,
    output logic     mem_ready,
    output logic     mem_req,
    output word_t    mem_value,
    output rob_tag_t mem_tag_out,
    output logic     mem_store_flag
);

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WAIT,
        MEM_RESP
    } mem_state_t;

    mem_state_t           state;
    logic [1:0]           lat_cnt;
    logic [ROB_DEPTH-1:0] sb_valid;
    mem_idx_t             sb_addr [ROB_DEPTH];
    word_t                sb_data [ROB_DEPTH];
    word_t                mem_q   [MEM_WORDS];
    mem_idx_t             req_idx;

    assign req_idx = mem_idx_t'(mem_addr >> 2);
    assign mem_req = (state == MEM_RESP);

    // A load waits until every buffered store has reached memory
    assign mem_ready = (state == MEM_IDLE) && (mem_is_store || (sb_valid == '0));

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= MEM_IDLE;
            lat_cnt  <= '0;
            sb_valid <= '0;
        end else begin
            if (ls_commit) begin
                sb_valid[ls_tag] <= 1'b0;
            end
            if (mem_issue && mem_is_store) begin
                sb_valid[mem_tag] <= 1'b1;
            end
            case (state)
                MEM_IDLE: begin
                    if (mem_issue) begin
                        lat_cnt <= mem_addr[3:2];
                        // Load latency grows with the word offset in the line
                        if (mem_is_store || (mem_addr[3:2] == 2'd0)) begin
                            state <= MEM_RESP;
                        end else begin
                            state <= MEM_WAIT;
                        end
                    end
                end
                MEM_WAIT: begin
                    if (lat_cnt == 2'd1) begin
                        state <= MEM_RESP;
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                MEM_RESP: begin
                    if (mem_grant) begin
                        state <= MEM_IDLE;
                    end
                end
                default: state <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ls_commit) begin
            mem_q[sb_addr[ls_tag]] <= sb_data[ls_tag];
        end
        if (mem_issue) begin
            mem_tag_out    <= mem_tag;
            mem_store_flag <= mem_is_store;
            if (mem_is_store) begin
                sb_addr[mem_tag] <= req_idx;
                sb_data[mem_tag] <= mem_data;
                mem_value        <= mem_data;
            end else begin
                mem_value <= mem_q[req_idx];
            end
        end
    end

    a_commit_valid_slot: assert property (@(posedge clk) disable iff (!rst)
        ls_commit |-> sb_valid[ls_tag])
        else $error("store release for tag %0d with no buffered store", ls_tag);

endmodule

// File: hw/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter
    import rob_pkg::*;
(
    input  logic     alu_req,
    input  word_t    alu_value,
    input  rob_tag_t alu_tag_out,
    input  logic     mem_req,
    input  word_t    mem_value,
    input  rob_tag_t mem_tag_out,
    input  logic     mem_store_flag,
    output logic     alu_grant,
    output logic     mem_grant,
    output logic     cdb_valid,
    output rob_tag_t cdb_tag,
    output word_t    cdb_value,
    output logic     cdb_store
);

    // Memory unit always wins
    always_comb begin
        mem_grant = mem_req;
        alu_grant = alu_req && !mem_req;
        cdb_valid = mem_req || alu_req;
        if (mem_req) begin
            cdb_tag   = mem_tag_out;
            cdb_value = mem_value;
            cdb_store = mem_store_flag;
        end else begin
            cdb_tag   = alu_tag_out;
            cdb_value = alu_value;
            cdb_store = 1'b0;
        end
    end

    always_comb begin
        a_one_grant: assert (!(alu_grant && mem_grant))
            else $error("both units granted the result bus");
    end

endmodule

// File: hw/ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top
    import rv_ops_pkg::*;
    import rob_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     dispatch,
    input  op_t      op,
    input  logic     use_imm,
    input  reg_idx_t rd,
    input  word_t    src1,
    input  word_t    src2,
    input  word_t    imm,
    input  word_t    pc,
    output logic     rob_full,
    output logic     commit,
    output rob_tag_t commit_tag,
    output reg_idx_t commit_rd,
    output word_t    commit_value,
    output logic     branch_taken,
    output word_t    branch_pc
);

    logic     alu_issue;
    op_t      alu_op;
    word_t    alu_a;
    word_t    alu_b;
    rob_tag_t alu_tag;
    logic     alu_ready;
    logic     alu_req;
    word_t    alu_value;
    rob_tag_t alu_tag_out;
    logic     alu_grant;

    logic     mem_issue;
    logic     mem_is_store;
    word_t    mem_addr;
    word_t    mem_data;
    rob_tag_t mem_tag;
    logic     mem_ready;
    logic     mem_req;
    word_t    mem_value;
    rob_tag_t mem_tag_out;
    logic     mem_store_flag;
    logic     mem_grant;

    logic     cdb_valid;
    rob_tag_t cdb_tag;
    word_t    cdb_value;
    logic     cdb_store;
    logic     ls_commit;
    rob_tag_t ls_tag;

    reorder_buffer u_rob (
        .clk          (clk),
        .rst          (rst),
        .dispatch     (dispatch),
        .op           (op),
        .use_imm      (use_imm),
        .rd           (rd),
        .src1         (src1),
        .src2         (src2),
        .imm          (imm),
        .pc           (pc),
        .alu_ready    (alu_ready),
        .mem_ready    (mem_ready),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .cdb_store    (cdb_store),
        .rob_full     (rob_full),
        .alu_issue    (alu_issue),
        .alu_op       (alu_op),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_tag      (alu_tag),
        .mem_issue    (mem_issue),
        .mem_is_store (mem_is_store),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .mem_tag      (mem_tag),
        .ls_commit    (ls_commit),
        .ls_tag       (ls_tag),
        .commit       (commit),
        .commit_tag   (commit_tag),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc)
    );

    alu_unit u_alu (
        .clk         (clk),
        .rst         (rst),
        .alu_issue   (alu_issue),
        .alu_op      (alu_op),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_tag     (alu_tag),
        .alu_grant   (alu_grant),
        .alu_ready   (alu_ready),
        .alu_req     (alu_req),
        .alu_value   (alu_value),
        .alu_tag_out (alu_tag_out)
    );

    mem_unit u_mem (
        .clk            (clk),
        .rst            (rst),
        .mem_issue      (mem_issue),
        .mem_is_store   (mem_is_store),
        .mem_addr       (mem_addr),
        .mem_data       (mem_data),
        .mem_tag        (mem_tag),
        .mem_grant      (mem_grant),
        .ls_commit      (ls_commit),
        .ls_tag         (ls_tag),
        .mem_ready      (mem_ready),
        .mem_req        (mem_req),
        .mem_value      (mem_value),
        .mem_tag_out    (mem_tag_out),
        .mem_store_flag (mem_store_flag)
    );

    cdb_arbiter u_arb (
        .alu_req        (alu_req),
        .alu_value      (alu_value),
        .alu_tag_out    (alu_tag_out),
        .mem_req        (mem_req),
        .mem_value      (mem_value),
        .mem_tag_out    (mem_tag_out),
        .mem_store_flag (mem_store_flag),
        .alu_grant      (alu_grant),
        .mem_grant      (mem_grant),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .cdb_store      (cdb_store)
    );

endmodule

// File: testbench/tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core
    import rv_ops_pkg::*;
    import rob_pkg::*;
();

    typedef struct packed {
        rob_tag_t tag;
        reg_idx_t rd;
        word_t    value;
        logic     is_br;
        logic     taken;
        word_t    target;
    } retire_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     dispatch;
    op_t      op;
    logic     use_imm;
    reg_idx_t rd;
    word_t    src1;
    word_t    src2;
    word_t    imm;
    word_t    pc;
    logic     rob_full;
    logic     commit;
    rob_tag_t commit_tag;
    reg_idx_t commit_rd;
    word_t    commit_value;
    logic     branch_taken;
    word_t    branch_pc;

    retire_t  exp_q [$];
    word_t    shadow [MEM_WORDS];
    word_t    seed = 32'h07ba_ca56;
    word_t    pc_next = 32'h0000_1000;
    rob_tag_t next_tag = '0;
    string    test_name = "reset";

    // Front of the retirement queue, refreshed between edges
    logic     exp_valid = 1'b0;
    rob_tag_t exp_tag = '0;
    reg_idx_t exp_rd = '0;
    word_t    exp_value = '0;
    logic     exp_is_br = 1'b0;
    logic     exp_taken = 1'b0;
    word_t    exp_target = '0;
    logic     retire_pending = 1'b0;
    int       accepted_total = 0;
    int       retired_total = 0;
    logic     model_full = 1'b0;
    logic     saw_full = 1'b0;

    ooo_core_top DUT (
        .clk          (clk),
        .rst          (rst),
        .dispatch     (dispatch),
        .op           (op),
        .use_imm      (use_imm),
        .rd           (rd),
        .src1         (src1),
        .src2         (src2),
        .imm          (imm),
        .pc           (pc),
        .rob_full     (rob_full),
        .commit       (commit),
        .commit_tag   (commit_tag),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc)
    );

    always #10 clk = ~clk;

    function automatic word_t next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic signed_less(word_t a, word_t b);
        // Differing signs, the negative operand is the smaller
        if (a[31] != b[31]) begin
            return a[31];
        end
        return a < b;
    endfunction

    function automatic word_t alu_expected(op_t o, word_t a, word_t b);
        case (o)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return signed_less(a, b) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic branch_holds(op_t o, word_t a, word_t b);
        case (o)
            OP_BEQ:  return a == b;
            OP_BNE:  return a != b;
            default: return signed_less(a, b);
        endcase
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_mismatch(input string field, input word_t expv, input word_t actv);
        stop_on_error($sformatf("FAIL %s %s: expected %h actual %h",
                                test_name, field, expv, actv));
    endtask

    // Called at a rising edge, returns at the edge that accepts the instruction
    task automatic dispatch_instr(input op_t o, input logic ui, input reg_idx_t r,
                                  input word_t a, input word_t b, input word_t im);
        retire_t e;
        word_t   eff_b;
        word_t   sum;
        int      waited;
        e.tag    = next_tag;
        e.rd     = r;
        e.value  = '0;
        e.is_br  = 1'b0;
        e.taken  = 1'b0;
        e.target = pc_next + im;
        eff_b    = (ui && (o inside {OP_ADD, OP_AND, OP_OR, OP_XOR, OP_SLT})) ? im : b;
        sum      = a + im;
        case (o)
            OP_LUI: e.value = im;
            OP_LW:  e.value = shadow[sum[7:2]];
            OP_SW: begin
                shadow[sum[7:2]] = b;
                e.rd = '0;
            end
            OP_BEQ, OP_BNE, OP_BLT: begin
                e.is_br = 1'b1;
                e.taken = branch_holds(o, a, b);
                e.rd    = '0;
            end
            default: e.value = alu_expected(o, a, eff_b);
        endcase
        dispatch <= 1'b1;
        op       <= o;
        use_imm  <= ui;
        rd       <= r;
        src1     <= a;
        src2     <= b;
        imm      <= im;
        pc       <= pc_next;
        pc_next  = pc_next + 32'd4;
        waited   = 0;
        @(negedge clk);
        while (rob_full) begin
            waited++;
            if (waited > 200) begin
                stop_on_error("timed out waiting for the reorder buffer to accept an instruction");
            end
            @(negedge clk);
        end
        @(posedge clk);
        exp_q.push_back(e);
        next_tag = next_tag + 1'b1;
        accepted_total++;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        dispatch <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 500) begin
                stop_on_error("timed out waiting for dispatched instructions to retire");
            end
        end
    endtask

    // A retirement checked at one edge leaves the queue at the next falling edge
    always @(negedge clk) begin
        if (retire_pending && (exp_q.size() != 0)) begin
            void'(exp_q.pop_front());
        end
        retire_pending = commit;
        if (commit) begin
            retired_total++;
        end
        if (rob_full) begin
            saw_full = 1'b1;
        end
        model_full = ((accepted_total - retired_total) == ROB_DEPTH);
        exp_valid  = (exp_q.size() != 0);
        if (exp_valid) begin
            exp_tag    = exp_q[0].tag;
            exp_rd     = exp_q[0].rd;
            exp_value  = exp_q[0].value;
            exp_is_br  = exp_q[0].is_br;
            exp_taken  = exp_q[0].taken;
            exp_target = exp_q[0].target;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        !rst |=> (!commit && !branch_taken && !rob_full))
        else stop_on_error("commit, branch_taken or rob_full is high right after reset");

    a_expected: assert property (@(posedge clk) disable iff (!rst) commit |-> exp_valid)
        else stop_on_error("an instruction retired that was never dispatched");

    a_tag: assert property (@(posedge clk) disable iff (!rst)
        commit |-> (commit_tag == exp_tag))
        else value_mismatch("commit_tag", word_t'(exp_tag), word_t'($sampled(commit_tag)));

    a_rd: assert property (@(posedge clk) disable iff (!rst)
        commit |-> (commit_rd == exp_rd))
        else value_mismatch("commit_rd", word_t'(exp_rd), word_t'($sampled(commit_rd)));

    a_value: assert property (@(posedge clk) disable iff (!rst)
        commit |-> (commit_value == exp_value))
        else value_mismatch("commit_value", exp_value, $sampled(commit_value));

    a_taken: assert property (@(posedge clk) disable iff (!rst)
        commit |-> (branch_taken == exp_taken))
        else value_mismatch("branch_taken", word_t'(exp_taken), word_t'($sampled(branch_taken)));

    a_target: assert property (@(posedge clk) disable iff (!rst)
        (commit && exp_is_br) |-> (branch_pc == exp_target))
        else value_mismatch("branch_pc", exp_target, $sampled(branch_pc));

    a_taken_alone: assert property (@(posedge clk) disable iff (!rst) branch_taken |-> commit)
        else stop_on_error("branch_taken pulsed without a retirement");

    a_full: assert property (@(posedge clk) disable iff (!rst) rob_full == model_full)
        else value_mismatch("rob_full", word_t'(model_full), word_t'($sampled(rob_full)));

    initial begin
        word_t r;
        word_t a;
        op_t   br_op;
        rst      = 1'b0;
        dispatch = 1'b0;
        op       = OP_ADD;
        use_imm  = 1'b0;
        rd       = '0;
        src1     = '0;
        src2     = '0;
        imm      = '0;
        pc       = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        repeat (10) @(posedge clk);

        // Every word gets written so later loads read defined data
        test_name = "store_load";
        for (int i = 0; i < MEM_WORDS; i++) begin
            dispatch_instr(OP_SW, 1'b0, 5'd0, word_t'(i) << 2, next_rand(), '0);
        end
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            a = r & 32'hffff_fffc;
            dispatch_instr(OP_SW, 1'b0, 5'd0, a, next_rand(), {26'b0, r[11:8], 2'b00});
            dispatch_instr(OP_LW, 1'b0, r[31:27], a + {26'b0, r[11:8], 2'b00}, '0, '0);
        end
        wait_drain();

        test_name = "in_order";
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            case (r[2:0])
                3'd6: dispatch_instr(OP_LUI, 1'b0, r[31:27], '0, '0, {r[31:12], 12'h000});
                3'd7: dispatch_instr(OP_LW, 1'b0, r[31:27], next_rand() & 32'hffff_fffc,
                                     '0, {26'b0, r[11:8], 2'b00});
                default: dispatch_instr(op_t'({1'b0, r[2:0]}), r[3], r[31:27], next_rand(),
                                        next_rand(), {{20{r[15]}}, r[15:4]});
            endcase
        end
        wait_drain();

        test_name = "branches";
        for (int i = 0; i < 24; i++) begin
            r = next_rand();
            a = next_rand();
            case (r[1:0])
                2'd0:    br_op = OP_BEQ;
                2'd1:    br_op = OP_BNE;
                default: br_op = OP_BLT;
            endcase
            dispatch_instr(br_op, 1'b0, 5'd0, a, r[4] ? a : next_rand(),
                           {{19{r[20]}}, r[20:9], 1'b0});
        end
        wait_drain();

        // Slowest loads at the head let the younger ops pile up
        test_name = "rob_full";
        saw_full  = 1'b0;
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            dispatch_instr(OP_LW, 1'b0, r[31:27], {r[31:4], 4'b1100}, '0, '0);
        end
        for (int i = 0; i < 12; i++) begin
            r = next_rand();
            dispatch_instr(OP_ADD, 1'b0, r[31:27], next_rand(), next_rand(), '0);
        end
        wait_drain();
        a_saw_full: assert (saw_full)
            else stop_on_error("rob_full never rose while loads blocked the head");

        repeat (5) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            stop_on_error("expected retirements are left over at the end of the run");
        end
    end

endmodule

// File: compile.f
hw/rv_ops_pkg.sv
hw/rob_pkg.sv
hw/reorder_buffer.sv
hw/alu_unit.sv
hw/mem_unit.sv
hw/cdb_arbiter.sv
hw/ooo_core_top.sv
testbench/tb_ooo_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ooo_core -f compile.f

out=$(./obj_dir/Vtb_ooo_core 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
